// File: common/sd_params.svh
// block size, lane bit count, CRC length and word buffer depth macros
`ifndef SD_PARAMS_SVH_
`define SD_PARAMS_SVH_

// one block is 512 bytes, sent as 32-bit words
`define SD_BLOCK_WORDS 128

// 512 bytes spread over four DAT lanes
`define SD_LANE_BITS 1024

// CRC16 appended to every lane
`define SD_CRC_BITS 16

// host-side word buffer, holds one full block
`define SD_FIFO_DEPTH 128

`endif

// File: common/sd_pkg.sv
// sd_word_u word union, sd_dat_bus_t data bus struct, dat_tx_state_e writer states
`default_nettype none

package sd_pkg;

  // one host word, seen as bytes by the host and as bus nibbles by the writer
  typedef union packed {
    logic [3:0][7:0]      bytes;  // byte 0 is bits 7..0
    logic [3:0][0:1][3:0] nib;    // nib[n/2][n%2] is bus nibble n, high nibble first
  } sd_word_u;

  // DAT lines plus the pad controls that stand in for tristate
  typedef struct packed {
    logic [3:0] dat;      // bit k drives DAT line k
    logic       oe;       // drive enable
    logic       pull_up;  // DAT0 pull-up request
  } sd_dat_bus_t;

  // block transmit sequence
  typedef enum logic [2:0] {
    READY,
    START_BIT,
    DAT,
    CRC,
    END_BIT
  } dat_tx_state_e;

endpackage

`default_nettype wire

// File: dat_write/crc16_write.sv
// per-lane serial CRC16 generator with remainder shift-out
`timescale 1ns/1ps
`default_nettype none
`include "sd_params.svh"

module crc16_write (
  input  wire logic sd_clk_i,
  input  wire logic rst_n_i,
  input  wire logic clear_i,      // start pulse, zeroes the remainder
  input  wire logic shift_out_i,  // high while the remainder goes onto the lane
  input  wire logic dat_ser_i,
  output logic      crc_ser_o
);

  // x^16 + x^12 + x^5 + 1
  localparam logic [`SD_CRC_BITS-1:0] Poly = 16'h1021;

  logic [`SD_CRC_BITS-1:0] crc_q;
  logic                    feedback;

  assign feedback = crc_q[`SD_CRC_BITS-1] ^ dat_ser_i;

  always_ff @(posedge sd_clk_i) begin
    if (!rst_n_i) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (shift_out_i) begin
      crc_q <= {crc_q[`SD_CRC_BITS-2:0], 1'b0};  // msb first onto the lane
    end else begin
      crc_q <= {crc_q[`SD_CRC_BITS-2:0], 1'b0} ^ (feedback ? Poly : '0);
    end
  end

  // current msb is the next remainder bit during shift-out
  assign crc_ser_o = crc_q[`SD_CRC_BITS-1];

endmodule

`default_nettype wire

// File: dat_write/dat_write.sv
// block transmit FSM, double-buffered lane shifters, bit counter and bus mux
`timescale 1ns/1ps
`default_nettype none
`include "sd_params.svh"

module dat_write import sd_pkg::*; (
  input  wire logic       sd_clk_i,
  input  wire logic       rst_n_i,
  input  wire logic       start_send_i,
  input  wire logic       stop_transmission_i,  // forces the end bit on the next cycle
  input  wire logic       pull_up_i,            // only passed to the bus while idle
  input  wire sd_word_u   dat_i_par,            // head word of the buffer
  output logic            next_word_o,          // word taken and popped this cycle
  output logic            start_accept_o,
  output sd_dat_bus_t     sd_dat_o,
  output logic            done_transmitting_o
);

  localparam logic [10:0] LastDatCnt = 11'(`SD_LANE_BITS - 1);
  localparam logic [10:0] LastCrcCnt = 11'(`SD_LANE_BITS + `SD_CRC_BITS - 1);

  dat_tx_state_e        state_d, state_q;
  logic [10:0]          count_q;     // data bits then CRC bits per lane
  logic [1:0][3:0][7:0] bank_q;      // [bank][lane][bit], msb goes out first
  logic [3:0][7:0]      lane_par;    // word split into one byte per lane
  logic [3:0]           dat_ser;
  logic [3:0]           crc_ser;
  logic                 bank_sel;
  logic                 load_sel;
  logic                 dat_done;
  logic                 crc_done;
  logic                 crc_clear;
  logic                 crc_shift;

  // lane k gets bit k of each nibble, nibble 0 first
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 8; n++) begin
        lane_par[k][7-n] = dat_i_par.nib[n/2][n%2][k];
      end
    end
  end

  assign bank_sel = count_q[3];                                 // bank that is shifting
  assign load_sel = (state_q == DAT) ? ~count_q[3] : 1'b0;      // word 0 always into bank 0
  assign dat_done = (count_q == LastDatCnt);
  assign crc_done = (count_q == LastCrcCnt);

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      dat_ser[k] = bank_q[bank_sel][k][7];
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY:     state_d = (start_send_i && !stop_transmission_i) ? START_BIT : READY;
      START_BIT: state_d = stop_transmission_i ? END_BIT : DAT;
      DAT:       state_d = stop_transmission_i ? END_BIT : (dat_done ? CRC : DAT);
      CRC:       state_d = (crc_done || stop_transmission_i) ? END_BIT : CRC;
      END_BIT:   state_d = READY;
      default:   state_d = READY;
    endcase
  end

  assign start_accept_o      = (state_q == READY) && (state_d == START_BIT);
  assign done_transmitting_o = (state_q == READY);

  always_ff @(posedge sd_clk_i) begin
    if (!rst_n_i) begin
      state_q <= READY;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == DAT || state_q == CRC) begin
        count_q <= count_q + 11'd1;
      end else begin
        count_q <= '0;  // start bit and data share count 0 at entry
      end
    end
  end

  // word 0 in the start bit, then one per 8-cycle slot except the last
  always_comb begin
    next_word_o = 1'b0;
    if (state_q == START_BIT) begin
      next_word_o = 1'b1;
    end else if (state_q == DAT && count_q[2:0] == 3'd7 &&
                 count_q[10:3] < 8'(`SD_BLOCK_WORDS - 1)) begin
      next_word_o = 1'b1;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (next_word_o) begin
      bank_q[load_sel] <= lane_par;  // idle bank, never the one shifting
    end
    if (state_q == DAT) begin
      for (int k = 0; k < 4; k++) begin
        bank_q[bank_sel][k] <= {bank_q[bank_sel][k][6:0], 1'b0};
      end
    end
  end

  assign crc_clear = (state_q == START_BIT);  // remainder starts at zero for the data
  assign crc_shift = (state_q == CRC);

  for (genvar k = 0; k < 4; k++) begin : g_lane_crc
    crc16_write i_crc16_write (
      .sd_clk_i    (sd_clk_i),
      .rst_n_i     (rst_n_i),
      .clear_i     (crc_clear),
      .shift_out_i (crc_shift),
      .dat_ser_i   (dat_ser[k]),
      .crc_ser_o   (crc_ser[k])
    );
  end

  always_comb begin
    sd_dat_o = '{dat: 4'hf, oe: 1'b1, pull_up: 1'b0};
    unique case (state_q)
      READY: begin
        sd_dat_o.oe      = 1'b0;       // card side owns the lines
        sd_dat_o.pull_up = pull_up_i;
      end
      START_BIT: sd_dat_o.dat = 4'h0;
      DAT:       sd_dat_o.dat = dat_ser;
      CRC:       sd_dat_o.dat = crc_ser;
      default:   ;                     // end bit, all lanes high
    endcase
  end

  // a word request leads into data or a stop, never into the CRC
  a_next_word_state: assert property (@(posedge sd_clk_i) disable iff (!rst_n_i)
    next_word_o |=> (state_q inside {DAT, END_BIT}));

  // the lines are only released right after an end bit
  a_idle_no_drive: assert property (@(posedge sd_clk_i) disable iff (!rst_n_i)
    $fell(sd_dat_o.oe) |-> ($past(state_q) == END_BIT));

endmodule

`default_nettype wire

// File: hdl/dat_word_fifo.sv
// circular word buffer between host writes and writer requests
`timescale 1ns/1ps
`default_nettype none
`include "sd_params.svh"

module dat_word_fifo import sd_pkg::*; (
  input  wire logic     sd_clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     clear_i,    // drops all buffered words
  input  wire logic     wr_en_i,
  input  wire sd_word_u wr_word_i,
  input  wire logic     rd_en_i,    // pop, head word is consumed this cycle
  input  wire logic     start_i,    // accepted start, clears underrun
  output sd_word_u      rd_word_o,
  output logic          full_o,
  output logic          underrun_o
);

  localparam int unsigned Depth = `SD_FIFO_DEPTH;
  localparam int unsigned AddrW = $clog2(Depth);
  localparam logic [AddrW:0] FullCnt = Depth[AddrW:0];

  sd_word_u         mem_q [Depth];
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW-1:0] rd_ptr_q;
  logic [AddrW:0]   fill_q;
  logic             empty;
  logic             do_wr;
  logic             do_rd;

  assign empty     = (fill_q == '0);
  assign full_o    = (fill_q == FullCnt);
  assign do_wr     = wr_en_i && !full_o;  // write into a full buffer is lost
  assign do_rd     = rd_en_i && !empty;
  assign rd_word_o = mem_q[rd_ptr_q];

  always_ff @(posedge sd_clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_word_i;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_wr && !do_rd) fill_q <= fill_q + 1'b1;
      else if (do_rd && !do_wr) fill_q <= fill_q - 1'b1;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (!rst_n_i) begin
      underrun_o <= 1'b0;
    end else if (start_i) begin
      underrun_o <= 1'b0;
    end else if (rd_en_i && empty) begin
      underrun_o <= 1'b1;  // sticky for the rest of the block
    end
  end

  a_fill_bound: assert property (@(posedge sd_clk_i) disable iff (!rst_n_i)
    fill_q <= FullCnt);

endmodule

`default_nettype wire

// File: hdl/sd_dat_tx_top.sv
// word buffer and data writer of the SD host write path
`timescale 1ns/1ps
`default_nettype none

module sd_dat_tx_top import sd_pkg::*; (
  input  wire logic     sd_clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     wr_en_i,
  input  wire sd_word_u wr_word_i,
  input  wire logic     start_send_i,
  input  wire logic     stop_transmission_i,
  input  wire logic     pull_up_i,
  output sd_dat_bus_t   sd_dat_o,
  output logic          fifo_full_o,
  output logic          underrun_o,
  output logic          done_transmitting_o
);

  sd_word_u rd_word;       // buffer head into the writer
  logic     next_word;     // writer pop
  logic     start_accept;

  dat_word_fifo i_dat_word_fifo (
    .sd_clk_i   (sd_clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (stop_transmission_i),  // a stop flushes pending data
    .wr_en_i    (wr_en_i),
    .wr_word_i  (wr_word_i),
    .rd_en_i    (next_word),
    .start_i    (start_accept),
    .rd_word_o  (rd_word),
    .full_o     (fifo_full_o),
    .underrun_o (underrun_o)
  );

  dat_write i_dat_write (
    .sd_clk_i            (sd_clk_i),
    .rst_n_i             (rst_n_i),
    .start_send_i        (start_send_i),
    .stop_transmission_i (stop_transmission_i),
    .pull_up_i           (pull_up_i),
    .dat_i_par           (rd_word),
    .next_word_o         (next_word),
    .start_accept_o      (start_accept),
    .sd_dat_o            (sd_dat_o),
    .done_transmitting_o (done_transmitting_o)
  );

endmodule

`default_nettype wire

// File: test/tb_sd_dat_tx.sv
// directed testbench with bus and CRC16 models, LCG word source and timeout
`timescale 1ns/1ps
`default_nettype none
`include "sd_params.svh"

module tb_sd_dat_tx import sd_pkg::*; ();

  localparam int BlockCycles   = 2 + `SD_LANE_BITS + `SD_CRC_BITS;  // start, data, crc, end
  // five full blocks, one cut block, about 650 word writes, then margin
  localparam int TimeoutCycles = 8000;

  logic        sd_clk_i;
  logic        rst_n_i;
  logic        wr_en_i;
  sd_word_u    wr_word_i;
  logic        start_send_i;
  logic        stop_transmission_i;
  logic        pull_up_i;
  sd_dat_bus_t sd_dat_o;
  logic        fifo_full_o;
  logic        underrun_o;
  logic        done_transmitting_o;

  sd_word_u    exp_words [`SD_BLOCK_WORDS];  // block contents as the host wrote them
  logic [31:0] lcg_state = 32'hdcad_edea;
  int          cycle_count = 0;

  sd_dat_tx_top dut_i (
    .sd_clk_i            (sd_clk_i),
    .rst_n_i             (rst_n_i),
    .wr_en_i             (wr_en_i),
    .wr_word_i           (wr_word_i),
    .start_send_i        (start_send_i),
    .stop_transmission_i (stop_transmission_i),
    .pull_up_i           (pull_up_i),
    .sd_dat_o            (sd_dat_o),
    .fifo_full_o         (fifo_full_o),
    .underrun_o          (underrun_o),
    .done_transmitting_o (done_transmitting_o)
  );

  initial begin
    sd_clk_i = 1'b0;
    forever #4 sd_clk_i = ~sd_clk_i;
  end

  always @(posedge sd_clk_i) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      stop_with_error("timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic value_check(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_with_error($sformatf("[ERROR] %s: expected %0h, actual %0h", what, exp, act));
    end
  endtask

  task automatic bus_check(input string what, input logic [3:0] dat, input logic oe,
                           input logic pull);
    value_check(what, 32'({dat, oe, pull}), 32'(sd_dat_o));
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // nibble n of a word: high then low nibble of byte n/2
  function automatic logic [3:0] expected_nibble(input int idx);
    sd_word_u   w;
    logic [7:0] b;
    int         n;
    w = exp_words[idx / 8];
    n = idx % 8;
    b = w.bytes[n / 2];
    return (n % 2 == 0) ? b[7:4] : b[3:0];
  endfunction

  // x^16 + x^12 + x^5 + 1, zero start, msb first
  function automatic logic [15:0] lane_crc(input int lane);
    logic [15:0] crc;
    logic [3:0]  nib;
    logic        fb;
    crc = '0;
    for (int i = 0; i < `SD_LANE_BITS; i++) begin
      nib = expected_nibble(i);
      fb  = crc[15] ^ nib[lane];
      crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    return crc;
  endfunction

  task automatic write_words(input int count);
    sd_word_u word;
    for (int i = 0; i < count; i++) begin
      word      = next_rand();
      wr_en_i   = 1'b1;
      wr_word_i = word;
      if (i < `SD_BLOCK_WORDS) exp_words[i] = word;  // extra words are expected to be lost
      @(negedge sd_clk_i);
    end
    wr_en_i = 1'b0;
  endtask

  task automatic wait_until_busy();
    while (done_transmitting_o) @(negedge sd_clk_i);
  endtask

  task automatic send_and_check_block(input string name, input bit mid_start);
    logic [15:0] crc_exp [4];
    logic [3:0]  crc_bits;
    int          pulses;
    for (int k = 0; k < 4; k++) begin
      crc_exp[k] = lane_crc(k);
    end
    pulses       = 0;
    start_send_i = 1'b1;
    @(negedge sd_clk_i);
    start_send_i = 1'b0;
    wait_until_busy();
    bus_check({name, " start bit"}, 4'h0, 1'b1, 1'b0);
    value_check({name, " underrun at start"}, 0, underrun_o);
    pulses += dut_i.next_word;
    for (int c = 0; c < `SD_LANE_BITS; c++) begin
      @(negedge sd_clk_i);
      bus_check($sformatf("%s data cycle %0d", name, c), expected_nibble(c), 1'b1, 1'b0);
      pulses += dut_i.next_word;
      start_send_i = mid_start && (c == 100);  // must be ignored while busy
    end
    value_check({name, " word requests"}, `SD_BLOCK_WORDS, pulses);
    for (int j = 0; j < `SD_CRC_BITS; j++) begin
      @(negedge sd_clk_i);
      for (int k = 0; k < 4; k++) begin
        crc_bits[k] = crc_exp[k][15-j];
      end
      bus_check($sformatf("%s crc bit %0d", name, j), crc_bits, 1'b1, 1'b0);
    end
    @(negedge sd_clk_i);
    bus_check({name, " end bit"}, 4'hf, 1'b1, 1'b0);
    @(negedge sd_clk_i);
    bus_check({name, " idle"}, 4'hf, 1'b0, pull_up_i);
    value_check({name, " done"}, 1, done_transmitting_o);
    value_check({name, " underrun"}, 0, underrun_o);
  endtask

  task automatic reset_idle_test();
    bus_check("reset_idle bus", 4'hf, 1'b0, 1'b0);
    value_check("reset_idle done", 1, done_transmitting_o);
    value_check("reset_idle underrun", 0, underrun_o);
    value_check("reset_idle full", 0, fifo_full_o);
    value_check("reset_idle next_word", 0, dut_i.next_word);
    pull_up_i = 1'b1;  // stays high, so active states must mask it
    @(negedge sd_clk_i);
    bus_check("reset_idle pull_up", 4'hf, 1'b0, 1'b1);
  endtask

  task automatic full_block_test();
    write_words(`SD_BLOCK_WORDS);
    send_and_check_block("full_block", 1'b0);
  endtask

  task automatic stop_mid_data_test();
    write_words(`SD_BLOCK_WORDS);
    start_send_i = 1'b1;
    @(negedge sd_clk_i);
    start_send_i = 1'b0;
    wait_until_busy();
    bus_check("stop_mid_data start bit", 4'h0, 1'b1, 1'b0);
    for (int c = 0; c < 300; c++) begin
      @(negedge sd_clk_i);
      bus_check($sformatf("stop_mid_data cycle %0d", c), expected_nibble(c), 1'b1, 1'b0);
    end
    stop_transmission_i = 1'b1;
    @(negedge sd_clk_i);
    stop_transmission_i = 1'b0;
    bus_check("stop_mid_data end bit", 4'hf, 1'b1, 1'b0);
    @(negedge sd_clk_i);
    bus_check("stop_mid_data idle", 4'hf, 1'b0, 1'b1);
    value_check("stop_mid_data done", 1, done_transmitting_o);
  endtask

  task automatic underrun_test();
    bit seen;
    seen = 1'b0;
    write_words(4);
    start_send_i = 1'b1;
    @(negedge sd_clk_i);
    start_send_i = 1'b0;
    wait_until_busy();
    while (!done_transmitting_o) begin
      @(negedge sd_clk_i);
      if (underrun_o) seen = 1'b1;
    end
    assert (seen) else begin
      stop_with_error("underrun: underrun_o never rose while the buffer ran dry");
    end
    value_check("underrun sticky", 1, underrun_o);
    // the next accepted start must clear the flag
    write_words(`SD_BLOCK_WORDS);
    send_and_check_block("underrun_clear", 1'b0);
  endtask

  task automatic buffer_full_test();
    write_words(`SD_BLOCK_WORDS + 1);
    value_check("buffer_full flag", 1, fifo_full_o);
    send_and_check_block("buffer_full", 1'b0);
    value_check("buffer_full flag after", 0, fifo_full_o);
  endtask

  task automatic ignored_start_test();
    start_send_i        = 1'b1;
    stop_transmission_i = 1'b1;
    @(negedge sd_clk_i);
    start_send_i        = 1'b0;
    stop_transmission_i = 1'b0;
    value_check("ignored_start done", 1, done_transmitting_o);
    bus_check("ignored_start bus", 4'hf, 1'b0, 1'b1);
    write_words(`SD_BLOCK_WORDS);
    send_and_check_block("ignored_start", 1'b1);
  endtask

  initial begin
    rst_n_i             = 1'b0;
    wr_en_i             = 1'b0;
    wr_word_i           = '0;
    start_send_i        = 1'b0;
    stop_transmission_i = 1'b0;
    pull_up_i           = 1'b0;
    repeat (3) @(negedge sd_clk_i);
    rst_n_i = 1'b1;
    @(negedge sd_clk_i);
    reset_idle_test();
    full_block_test();
    stop_mid_data_test();
    underrun_test();
    buffer_full_test();
    ignored_start_test();
    $display("block length %0d cycles, run took %0d cycles", BlockCycles, cycle_count);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/sd_pkg.sv
dat_write/crc16_write.sv
dat_write/dat_write.sv
hdl/dat_word_fifo.sv
hdl/sd_dat_tx_top.sv
test/tb_sd_dat_tx.sv

// File: Makefile
# Verilator build and run of the SD data write path testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_sd_dat_tx -Mdir obj_dir
	./obj_dir/Vtb_sd_dat_tx | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
